// ==== tb.f ====
design/pm_pkg.sv
design/univib.sv
design/cycle_ctl.sv
design/state_seq.sv
design/microop_dec.sv
design/pm_top.sv
verification/tb_pm.sv

// ==== verification/tb_pm.sv ====
// ****************************************
// tb_pm
// testbench for the P-M cycle control,
// program run against a reference model
// ****************************************
`timescale 1ns/1ps

module tb_pm;

	localparam int n_instr = 23;
	localparam int cycle_limit = 30 * n_instr + 200;

	logic __clk = 1'b0;
	logic rst_n;
	logic start_sw;
	logic stop_sw;
	logic cycle_sw;
	logic irq;
	pm_pkg::word_t ir;
	logic run;
	logic waiting;
	logic fetch_start;
	logic irq_accept;
	pm_pkg::pm_state_t state;
	logic w_ir;
	logic w_ic;
	logic w_ar;
	logic w_ac;

	pm_pkg::word_t prog [0:31];
	// each entry holds op, state, fetch_start, irq_accept, run and waiting
	logic [12:0] exp_q [$];
	int pidx;
	int cycles;
	logic [5:0] cur_op;
	logic [1:0] exp_mc;
	logic exp_start;
	logic exp_wait;
	logic irq_lvl;

	pm_top DUT (
		.__clk(__clk), .rst_n(rst_n), .start_sw(start_sw), .stop_sw(stop_sw),
		.cycle_sw(cycle_sw), .irq(irq), .ir(ir), .run(run), .waiting(waiting),
		.fetch_start(fetch_start), .irq_accept(irq_accept), .state(state),
		.w_ir(w_ir), .w_ic(w_ic), .w_ar(w_ar), .w_ac(w_ac)
	);

	always #50 __clk = ~__clk;

	// expected state path of one instruction and the MC it leaves
	function automatic void path_of(input logic [15:0] w, input logic [1:0] m,
		output logic [2:0] sts [0:19], output int n, output logic [1:0] nm);
		int pw_len;
		logic na;
		logic [3:0] incl;
		na = !w[15];
		// bit 0 is P2 up to bit 3 for P5
		incl = {na && w[9], na && w[5:3] != 3'd0, na && m != 2'd0, na && w[2:0] == 3'd0};
		pw_len = (w[15:10] == 6'd33 && w[3:0] > 4'd1) ? int'(w[3:0]) : 1;
		sts[0] = 3'd1;
		n = 1;
		for (int i = 0; i < 4; i++) begin
			if (incl[i]) begin
				sts[n] = 3'(i + 2);
				n = n + 1;
			end
		end
		for (int i = 0; i < pw_len; i++) begin
			sts[n] = 3'd6;
			n = n + 1;
		end
		if (w[15:10] != 6'd2) nm = 2'd0;
		else nm = (m == 2'd3) ? 2'd3 : m + 2'd1;
	endfunction

	// expected {w_ir, w_ic, w_ar, w_ac}
	function automatic logic [3:0] strobes_of(input logic [2:0] st, input logic [5:0] op);
		case (st)
			3'd1: return 4'b1100;
			3'd2: return 4'b0110;
			3'd3, 3'd4, 3'd5: return 4'b0010;
			3'd6: return {3'b000, op == 6'd1};
			default: return 4'b0000;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// drive one cycle and queue what the DUT should show in it
	task automatic cyc(input logic [2:0] st, input logic fs, input logic ia,
		input logic [2:0] sw);
		@(posedge __clk);
		start_sw <= sw[2];
		stop_sw <= sw[1];
		cycle_sw <= sw[0];
		irq <= irq_lvl;
		exp_q.push_back({cur_op, st, fs, ia, exp_start & ~exp_wait, exp_wait});
		if (sw[1]) exp_start = 1'b0;
		else if (sw[2]) exp_start = 1'b1;
		if (ia || sw[1]) exp_wait = 1'b0;
	endtask

	task automatic gap(input int n);
		repeat (n) cyc(3'd0, 1'b0, 1'b0, 3'b000);
	endtask

	// fetch cycle then the whole state path with stop_sw optionally pressed in P1
	task automatic run_instr(input logic [15:0] w, input logic stop_p1);
		logic [2:0] sts [0:19];
		int n;
		logic [1:0] nm;
		path_of(w, exp_mc, sts, n, nm);
		cur_op = w[15:10];
		cyc(3'd0, 1'b1, 1'b0, 3'b000);
		for (int i = 0; i < n; i++) begin
			cyc(sts[i], 1'b0, 1'b0, (i == 0 && stop_p1) ? 3'b010 : 3'b000);
		end
		exp_mc = nm;
		if (w[15:10] == 6'd32) exp_wait = 1'b1;
	endtask

	function automatic logic [15:0] rand_word(input logic [5:0] op);
		logic [2:0] c;
		c = ($urandom % 2) ? 3'd0 : 3'($urandom);
		return {op, 1'($urandom), 3'($urandom), 3'($urandom), c};
	endfunction

	// next instruction word after each fetch
	always @(posedge __clk) begin
		if (w_ir) begin
			pidx = pidx + 1;
			ir <= prog[pidx];
		end
	end

	always @(negedge __clk) begin
		logic [12:0] e;
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			check("state", e[6:4], state);
			check("fetch_start", e[3], fetch_start);
			check("irq_accept", e[2], irq_accept);
			check("run", e[1], run);
			check("waiting", e[0], waiting);
			check("w_ir,w_ic,w_ar,w_ac", strobes_of(e[6:4], e[12:7]), {w_ir, w_ic, w_ar, w_ac});
		end
	end

	always @(posedge __clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	initial begin
		void'($urandom(32'h4296b442));
		for (int i = 0; i < 32; i++) prog[i] = 16'h0000;
		for (int i = 0; i < 8; i++) prog[i] = rand_word((i % 2) ? 6'd5 : 6'd1);
		for (int i = 8; i < 12; i++) prog[i] = rand_word(6'd2);
		prog[12] = rand_word(6'd1);
		prog[13] = {6'd33, 10'd0};
		prog[14] = {6'd33, 6'd0, 4'(2 + $urandom % 14)};
		prog[15] = {6'd32, 10'd0};
		prog[16] = rand_word(6'd1);
		prog[17] = rand_word(6'd2);
		prog[18] = rand_word(6'd1);
		for (int i = 19; i < n_instr; i++) prog[i] = rand_word(6'd1);
		pidx = 0;
		cycles = 0;
		cur_op = 6'd0;
		exp_mc = 2'd0;
		exp_start = 1'b0;
		exp_wait = 1'b0;
		irq_lvl = 1'b0;
		rst_n = 1'b0;
		start_sw = 1'b0;
		stop_sw = 1'b0;
		cycle_sw = 1'b0;
		irq = 1'b0;
		ir = prog[0];
		gap(4);
		rst_n <= 1'b1;
		gap(20);
		cyc(3'd0, 1'b0, 1'b0, 3'b100);
		gap(14);
		for (int i = 0; i < 15; i++) begin
			run_instr(prog[i], 1'b0);
			gap(13);
		end
		// halt and wake up on an interrupt
		run_instr(prog[15], 1'b0);
		gap(24);
		irq_lvl = 1'b1;
		gap(14);
		cyc(3'd0, 1'b0, 1'b1, 3'b000);
		irq_lvl = 1'b0;
		gap(13);
		run_instr(prog[16], 1'b0);
		gap(13);
		// irq held off by the premodification
		run_instr(prog[17], 1'b0);
		irq_lvl = 1'b1;
		gap(13);
		run_instr(prog[18], 1'b0);
		gap(13);
		cyc(3'd0, 1'b0, 1'b1, 3'b000);
		irq_lvl = 1'b0;
		gap(13);
		run_instr(prog[19], 1'b0);
		gap(13);
		run_instr(prog[20], 1'b1);
		gap(14);
		for (int k = 0; k < 2; k++) begin
			cyc(3'd0, 1'b0, 1'b0, 3'b001);
			gap(13);
			run_instr(prog[21 + k], 1'b0);
			gap(14);
		end
		@(negedge __clk);
		#1;
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== design/pm_top.sv ====
// ****************************************
// pm_top
// P-M instruction-cycle control top level
// ****************************************
`timescale 1ns/1ps

module pm_top #(
	parameter int kc_ticks = 7,
	parameter int pc_ticks = 6
) (
	input  logic              __clk,
	input  logic              rst_n,
	input  logic              start_sw,
	input  logic              stop_sw,
	input  logic              cycle_sw,
	input  logic              irq,
	input  pm_pkg::word_t     ir,
	output logic              run,
	output logic              waiting,
	output logic              fetch_start,
	output logic              irq_accept,
	output pm_pkg::pm_state_t state,
	output logic              w_ir,
	output logic              w_ic,
	output logic              w_ar,
	output logic              w_ac
);

	logic            ekc;
	logic            hlt_exec;
	logic            mc_zero;
	pm_pkg::opcode_t op;

	cycle_ctl #(
		.kc_ticks(kc_ticks),
		.pc_ticks(pc_ticks)
	) u_cycle_ctl (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.start_sw   (start_sw),
		.stop_sw    (stop_sw),
		.cycle_sw   (cycle_sw),
		.irq        (irq),
		.ekc        (ekc),
		.hlt_exec   (hlt_exec),
		.mc_zero    (mc_zero),
		.run        (run),
		.waiting    (waiting),
		.fetch_start(fetch_start),
		.irq_accept (irq_accept)
	);

	state_seq u_state_seq (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.fetch_start(fetch_start),
		.ir         (ir),
		.state      (state),
		.op         (op),
		.ekc        (ekc),
		.hlt_exec   (hlt_exec),
		.mc_zero    (mc_zero)
	);

	microop_dec u_microop_dec (
		.state(state),
		.op   (op),
		.w_ir (w_ir),
		.w_ic (w_ic),
		.w_ar (w_ar),
		.w_ac (w_ac)
	);

endmodule

// ==== design/microop_dec.sv ====
// ****************************************
// microop_dec
// W bus transfer strobes decoded from the
// main loop state and opcode
// ****************************************
`timescale 1ns/1ps

module microop_dec (
	input  pm_pkg::pm_state_t state,
	input  pm_pkg::opcode_t   op,
	output logic              w_ir,
	output logic              w_ic,
	output logic              w_ar,
	output logic              w_ac
);

	always_comb begin
		w_ir = 1'b0;
		w_ic = 1'b0;
		w_ar = 1'b0;
		w_ac = 1'b0;
		case (state)
			// fetch, word into IR and IC advanced
			pm_pkg::st_p1: begin
				w_ir = 1'b1;
				w_ic = 1'b1;
			end
			// argument word, IC steps over it into AR
			pm_pkg::st_p2: begin
				w_ic = 1'b1;
				w_ar = 1'b1;
			end
			// modification steps all rebuild the address
			pm_pkg::st_p3,
			pm_pkg::st_p4,
			pm_pkg::st_p5: begin
				w_ar = 1'b1;
			end
			pm_pkg::st_pw: begin
				// load writes the argument into AC
				w_ac = (op == pm_pkg::op_lw);
			end
			default: begin
				w_ir = 1'b0;
			end
		endcase
	end

endmodule

// ==== design/state_seq.sv ====
// ****************************************
// state_seq
// main loop FSM with instruction latch,
// MC premod and LK step counters
// ****************************************
`timescale 1ns/1ps

module state_seq (
	input  logic              __clk,
	input  logic              rst_n,
	input  logic              fetch_start,
	input  pm_pkg::word_t     ir,
	output pm_pkg::pm_state_t state,
	output pm_pkg::opcode_t   op,
	output logic              ekc,
	output logic              hlt_exec,
	output logic              mc_zero
);

	pm_pkg::word_t     ir_q;
	pm_pkg::word_t     cur_word;
	pm_pkg::mc_t       mc;
	pm_pkg::lk_t       lk;
	pm_pkg::pm_state_t state_nx;
	logic              pw_last;

	// next state after cur, taking P2..P5 in order when their condition holds
	function automatic pm_pkg::pm_state_t next_from(
		input pm_pkg::pm_state_t cur,
		input pm_pkg::word_t     w,
		input pm_pkg::mc_t       m
	);
		pm_pkg::pm_state_t nx;
		logic na;
		na = pm_pkg::f_na(w);
		nx = pm_pkg::st_pw;
		if (na && pm_pkg::f_d(w) && cur < pm_pkg::st_p5) begin
			nx = pm_pkg::st_p5;
		end
		if (na && pm_pkg::f_b(w) != 3'd0 && cur < pm_pkg::st_p4) begin
			nx = pm_pkg::st_p4;
		end
		if (na && m != 2'd0 && cur < pm_pkg::st_p3) begin
			nx = pm_pkg::st_p3;
		end
		if (na && pm_pkg::f_c(w) == 3'd0 && cur < pm_pkg::st_p2) begin
			nx = pm_pkg::st_p2;
		end
		return nx;
	endfunction

	// in P1 the word is still on the input, later it comes from the latch
	assign cur_word = (state == pm_pkg::st_p1) ? ir : ir_q;
	assign op = pm_pkg::f_op(ir_q);

	assign pw_last = (op != pm_pkg::op_shc) || (lk <= 4'd1);
	assign ekc = (state == pm_pkg::st_pw) && pw_last;
	assign hlt_exec = ekc && (op == pm_pkg::op_hlt);
	assign mc_zero = (mc == 2'd0);

	always_comb begin
		case (state)
			pm_pkg::st_p0: state_nx = fetch_start ? pm_pkg::st_p1 : pm_pkg::st_p0;
			pm_pkg::st_pw: state_nx = pw_last ? pm_pkg::st_p0 : pm_pkg::st_pw;
			default: state_nx = next_from(state, cur_word, mc);
		endcase
	end

	always_ff @(posedge __clk) begin
		if (state == pm_pkg::st_p1) begin
			ir_q <= ir;
		end
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= pm_pkg::st_p0;
			mc <= 2'd0;
			lk <= 4'd0;
		end else begin
			state <= state_nx;
			if (state == pm_pkg::st_p1) begin
				// shifts load the step count, everything else leaves LK clear
				if (pm_pkg::f_op(ir) == pm_pkg::op_shc) begin
					lk <= pm_pkg::f_cnt(ir);
				end else begin
					lk <= 4'd0;
				end
			end else if (state == pm_pkg::st_pw) begin
				if (pw_last) begin
					lk <= 4'd0;
					if (op != pm_pkg::op_md) begin
						mc <= 2'd0;
					end else if (mc != 2'd3) begin
						mc <= mc + 2'd1;
					end
				end else begin
					lk <= lk - 4'd1;
				end
			end
		end
	end

endmodule

// ==== design/cycle_ctl.sv ====
// ****************************************
// cycle_ctl
// START/WAIT flags, KC and PC one-shots and
// the fetch or interrupt decision
// ****************************************
`timescale 1ns/1ps

module cycle_ctl #(
	parameter int kc_ticks = 7,
	parameter int pc_ticks = 6
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic start_sw,
	input  logic stop_sw,
	input  logic cycle_sw,
	input  logic irq,
	input  logic ekc,
	input  logic hlt_exec,
	input  logic mc_zero,
	output logic run,
	output logic waiting,
	output logic fetch_start,
	output logic irq_accept
);

	// the KC falling-edge cycle is the first PC tick
	localparam int pc_hold = pc_ticks - 1;

	logic start;
	logic active;
	logic step;
	logic kc;
	logic kc_d;
	logic kc_fall;
	logic pc;
	logic pc_win;
	logic pc_win_d;
	logic decide;
	logic irq_take;
	logic go_idle;
	logic idle_req;
	logic trig;

	assign run = start & ~waiting;

	assign kc_fall = kc_d & ~kc;
	assign pc_win = kc_fall | pc;
	assign decide = pc_win_d & ~pc_win;

	// interrupt only between instructions, never after a premodification
	assign irq_take = start & irq & mc_zero;
	assign irq_accept = decide & irq_take;
	assign fetch_start = decide & ~irq_take & (run | step);
	assign go_idle = decide & ~irq_take & ~(run | step);

	assign idle_req = ~active & (cycle_sw | (start & (run | irq)));
	assign trig = ~(kc | pc_win) & (ekc | irq_accept | idle_req);

	univib #(.ticks(kc_ticks)) kc_vib (
		.__clk(__clk),
		.rst_n(rst_n),
		.trig (trig),
		.q    (kc)
	);

	univib #(.ticks(pc_hold)) pc_vib (
		.__clk(__clk),
		.rst_n(rst_n),
		.trig (kc_fall),
		.q    (pc)
	);

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
			waiting <= 1'b0;
			active <= 1'b0;
			step <= 1'b0;
			kc_d <= 1'b0;
			pc_win_d <= 1'b0;
		end else begin
			kc_d <= kc;
			pc_win_d <= pc_win;
			if (stop_sw) begin
				start <= 1'b0;
			end else if (start_sw) begin
				start <= 1'b1;
			end
			if (stop_sw || irq_accept) begin
				waiting <= 1'b0;
			end else if (hlt_exec) begin
				waiting <= 1'b1;
			end
			// step marks a chain started by the single-cycle switch
			if (trig) begin
				active <= 1'b1;
				step <= idle_req & cycle_sw;
			end else if (go_idle) begin
				active <= 1'b0;
			end
		end
	end

endmodule

// ==== design/univib.sv ====
// ****************************************
// univib
// clocked one-shot, output high for ticks
// clocks after a trigger
// ****************************************
`timescale 1ns/1ps

module univib #(
	parameter int ticks = 7
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic trig,
	output logic q
);

	localparam int cw = (ticks < 2) ? 1 : $clog2(ticks + 1);

	logic [cw-1:0] cnt;

	// a trigger while the pulse is running is ignored
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else if (trig) begin
			cnt <= cw'(ticks);
		end
	end

	assign q = (cnt != '0);

endmodule

// ==== design/pm_pkg.sv ====
// ****************************************
// pm_pkg
// shared types and opcode constants for
// the P-M instruction-cycle control
// ****************************************
package pm_pkg;

	// main loop states, P0 is idle or between cycles
	typedef enum logic [2:0] {
		st_p0 = 3'd0,
		st_p1 = 3'd1,
		st_p2 = 3'd2,
		st_p3 = 3'd3,
		st_p4 = 3'd4,
		st_p5 = 3'd5,
		st_pw = 3'd6
	} pm_state_t;

	typedef logic [15:0] word_t;
	typedef logic [5:0] opcode_t;
	typedef logic [1:0] mc_t;
	typedef logic [3:0] lk_t;

	localparam opcode_t op_lw = 6'd1;
	localparam opcode_t op_md = 6'd2;
	localparam opcode_t op_hlt = 6'd32;
	localparam opcode_t op_shc = 6'd33;

	// instruction word fields
	function automatic opcode_t f_op(input word_t w);
		return w[15:10];
	endfunction

	function automatic logic f_na(input word_t w);
		return ~w[15];
	endfunction

	function automatic logic f_d(input word_t w);
		return w[9];
	endfunction

	function automatic logic [2:0] f_b(input word_t w);
		return w[5:3];
	endfunction

	function automatic logic [2:0] f_c(input word_t w);
		return w[2:0];
	endfunction

	// shift count, shares bits with b and c
	function automatic lk_t f_cnt(input word_t w);
		return w[3:0];
	endfunction

endpackage
